/* cpu_types_pkg.sv */
package cpu_types_pkg;

	typedef logic [31:0] word_t;

	// cache geometry
	localparam int INDEX_W = 3;
	localparam int BLK_WORDS = 2;
	localparam int TAG_W = 26;

	typedef struct packed {
		logic [TAG_W-1:0]   tag;
		logic [INDEX_W-1:0] idx;
		logic               blkoff;
		logic [1:0]         byteoff;
	} dcache_addr_t;

	// raw word for the bus, fields for the lookup
	typedef union packed {
		word_t        raw;
		dcache_addr_t fld;
	} dcache_addr_u;

	typedef struct packed {
		logic         ren;
		logic         wen;
		dcache_addr_u addr;
		word_t        store;
	} dp_req_t;

	typedef struct packed {
		logic  hit;
		word_t load;
	} dp_rsp_t;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		word_t adr;
		word_t dat;
	} wb_m2s_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_s2m_t;

	typedef struct packed {
		logic enable;
	} csr_cfg_t;

	typedef struct packed {
		logic hit_evt;
		logic miss_evt;
	} csr_evt_t;

	localparam word_t CSR_CTRL = 32'h0000_0000;
	localparam word_t CSR_HITS = 32'h0000_0004;
	localparam word_t CSR_MISSES = 32'h0000_0008;

endpackage

/* dcache_array.sv */
`timescale 1ns/1ps

module dcache_array (
	input  logic                              CLK,
	input  logic                              rst_n,
	input  cpu_types_pkg::dcache_addr_u       addr,
	output logic                              tag_match,
	output logic                              valid,
	output logic                              dirty,
	output logic [cpu_types_pkg::TAG_W-1:0]   victim_tag,
	output cpu_types_pkg::word_t              rdata,
	input  logic                              fill_we,
	input  logic                              fill_blkoff,
	input  cpu_types_pkg::word_t              fill_data,
	input  logic                              store_we,
	input  cpu_types_pkg::word_t              store_data,
	input  logic                              set_valid,
	input  logic [cpu_types_pkg::INDEX_W-1:0] flush_idx,
	input  logic                              use_flush_idx,
	input  logic                              clear_dirty
);
	import cpu_types_pkg::*;

	localparam int SETS = 2 ** INDEX_W;

	logic [TAG_W-1:0] tag_q [SETS];
	word_t data_q [SETS][BLK_WORDS];
	logic [SETS-1:0] valid_q;
	logic [SETS-1:0] dirty_q;
	logic [INDEX_W-1:0] sel_idx;

	// flush walks the sets by its own counter
	assign sel_idx = use_flush_idx ? flush_idx : addr.fld.idx;

	assign valid = valid_q[sel_idx];
	assign dirty = dirty_q[sel_idx];
	assign victim_tag = tag_q[sel_idx];
	assign tag_match = valid_q[sel_idx] && (tag_q[sel_idx] == addr.fld.tag);
	assign rdata = data_q[sel_idx][addr.fld.blkoff];

	always_ff @(posedge CLK)
	begin
		if (set_valid)
			tag_q[sel_idx] <= addr.fld.tag;
		if (fill_we)
			data_q[sel_idx][fill_blkoff] <= fill_data;
		else if (store_we)
			data_q[sel_idx][addr.fld.blkoff] <= store_data;
	end

	always_ff @(posedge CLK)
	begin
		if (!rst_n)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else
		begin
			if (set_valid)
			begin
				valid_q[sel_idx] <= 1'b1;
				dirty_q[sel_idx] <= 1'b0;
			end
			// store marks the block dirty
			if (store_we)
				dirty_q[sel_idx] <= 1'b1;
			else if (clear_dirty)
				dirty_q[sel_idx] <= 1'b0;
		end
	end

endmodule

/* dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
	input  logic                              CLK,
	input  logic                              rst_n,
	input  cpu_types_pkg::dp_req_t            req,
	input  logic                              halt,
	output cpu_types_pkg::dp_rsp_t            rsp,
	output logic                              flushed,
	input  cpu_types_pkg::csr_cfg_t           cfg,
	output cpu_types_pkg::csr_evt_t           evt,
	output cpu_types_pkg::wb_m2s_t            mem_o,
	input  cpu_types_pkg::wb_s2m_t            mem_i,
	output cpu_types_pkg::dcache_addr_u       addr,
	input  logic                              tag_match,
	input  logic                              valid,
	input  logic                              dirty,
	input  logic [cpu_types_pkg::TAG_W-1:0]   victim_tag,
	input  cpu_types_pkg::word_t              rdata,
	output logic                              fill_we,
	output logic                              fill_blkoff,
	output cpu_types_pkg::word_t              fill_data,
	output logic                              store_we,
	output cpu_types_pkg::word_t              store_data,
	output logic                              set_valid,
	output logic [cpu_types_pkg::INDEX_W-1:0] flush_idx,
	output logic                              use_flush_idx,
	output logic                              clear_dirty
);
	import cpu_types_pkg::*;

	localparam int WCNT_W = $clog2(BLK_WORDS);

	typedef enum logic [2:0] {
		S_IDLE, S_WB, S_FETCH, S_BYPASS, S_FLUSH, S_HALTED
	} state_t;

	state_t state, state_n;
	logic [WCNT_W-1:0] wcnt, wcnt_n;
	logic [INDEX_W-1:0] sidx, sidx_n;
	logic ack_q;
	logic retry, retry_n;
	logic byp_done;
	word_t byp_data;
	logic bus_req;
	logic xfer;
	logic acked;
	logic last_word;
	logic req_valid;
	dcache_addr_u bus_addr;

	assign req_valid = req.ren || req.wen;
	assign xfer = (state == S_WB) || (state == S_FETCH) || (state == S_FLUSH);
	assign acked = mem_o.stb && mem_i.ack;
	assign last_word = (wcnt == WCNT_W'(BLK_WORDS - 1));
	assign flushed = (state == S_HALTED);
	assign flush_idx = sidx;
	assign use_flush_idx = (state == S_FLUSH);
	assign fill_data = mem_i.dat;
	assign fill_blkoff = wcnt;
	assign store_data = req.store;

	// block offset follows the word counter during block transfers
	always_comb
	begin
		addr = req.addr;
		if (xfer)
			addr.fld.blkoff = wcnt;
	end

	always_comb
	begin
		bus_addr = addr;
		if (xfer)
			bus_addr.fld.byteoff = '0;
		if (state == S_WB || state == S_FLUSH)
			bus_addr.fld.tag = victim_tag;
		if (state == S_FLUSH)
			bus_addr.fld.idx = sidx;
	end

	always_comb
	begin
		case (state)
			S_WB, S_FETCH, S_BYPASS: bus_req = 1'b1;
			S_FLUSH: bus_req = valid && dirty;
			default: bus_req = 1'b0;
		endcase
	end

	// one idle cycle after every ack
	always_comb
	begin
		mem_o.cyc = bus_req && !ack_q;
		mem_o.stb = bus_req && !ack_q;
		mem_o.we = (state == S_WB) || (state == S_FLUSH) || (state == S_BYPASS && req.wen);
		mem_o.adr = bus_addr.raw;
		mem_o.dat = (state == S_BYPASS) ? req.store : rdata;
	end

	always_comb
	begin
		state_n = state;
		wcnt_n = wcnt;
		sidx_n = sidx;
		retry_n = 1'b0;
		rsp.hit = 1'b0;
		rsp.load = byp_done ? byp_data : rdata;
		evt = '0;
		fill_we = 1'b0;
		store_we = 1'b0;
		set_valid = 1'b0;
		clear_dirty = 1'b0;
		case (state)
			S_IDLE:
			begin
				wcnt_n = '0;
				if (byp_done)
					rsp.hit = 1'b1;
				else if (halt)
				begin
					sidx_n = '0;
					state_n = S_FLUSH;
				end
				else if (req_valid && !cfg.enable)
				begin
					evt.miss_evt = 1'b1;
					state_n = S_BYPASS;
				end
				else if (req_valid && tag_match)
				begin
					rsp.hit = 1'b1;
					store_we = req.wen;
					// the replay after a refill is not a fresh hit
					evt.hit_evt = !retry;
				end
				else if (req_valid)
				begin
					evt.miss_evt = 1'b1;
					state_n = (valid && dirty) ? S_WB : S_FETCH;
				end
			end
			S_WB:
			begin
				if (acked)
				begin
					wcnt_n = wcnt + WCNT_W'(1);
					if (last_word)
						state_n = S_FETCH;
				end
			end
			S_FETCH:
			begin
				if (acked)
				begin
					fill_we = 1'b1;
					wcnt_n = wcnt + WCNT_W'(1);
					if (last_word)
					begin
						set_valid = 1'b1;
						retry_n = 1'b1;
						state_n = S_IDLE;
					end
				end
			end
			S_BYPASS:
			begin
				if (acked)
					state_n = S_IDLE;
			end
			S_FLUSH:
			begin
				// clean sets are skipped in one cycle
				if (!(valid && dirty) || (acked && last_word))
				begin
					clear_dirty = valid && dirty;
					sidx_n = sidx + INDEX_W'(1);
					if (sidx == '1)
						state_n = S_HALTED;
				end
				if (acked)
					wcnt_n = wcnt + WCNT_W'(1);
			end
			default:
			begin
				state_n = state;
			end
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			wcnt <= '0;
			sidx <= '0;
			ack_q <= 1'b0;
			retry <= 1'b0;
			byp_done <= 1'b0;
		end
		else
		begin
			state <= state_n;
			wcnt <= wcnt_n;
			sidx <= sidx_n;
			ack_q <= acked;
			retry <= retry_n;
			byp_done <= (state == S_BYPASS) && acked;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (acked)
			byp_data <= mem_i.dat;
	end

	a_drop_after_ack: assert property (@(posedge CLK) disable iff (!rst_n)
		mem_o.stb && mem_i.ack |=> !mem_o.stb && !mem_o.cyc);
	a_bus_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		mem_o.stb && !mem_i.ack |=> $stable(mem_o.adr) && $stable(mem_o.we));
	// once halted no dirty block is left behind
	a_no_hit_halted: assert property (@(posedge CLK) disable iff (!rst_n)
		state == S_HALTED |-> !rsp.hit && !dirty);

endmodule

/* dcache_csr.sv */
`timescale 1ns/1ps

module dcache_csr (
	input  logic                    CLK,
	input  logic                    rst_n,
	input  cpu_types_pkg::wb_m2s_t  csr_i,
	output cpu_types_pkg::wb_s2m_t  csr_o,
	output cpu_types_pkg::csr_cfg_t cfg,
	input  cpu_types_pkg::csr_evt_t evt
);
	import cpu_types_pkg::*;

	logic ack_q;
	logic enable_q;
	word_t hits_q;
	word_t misses_q;
	word_t rdat;
	word_t rdat_q;
	logic access;
	logic ctrl_wr;

	// no second ack while the master still holds stb
	assign access = csr_i.cyc && csr_i.stb && !ack_q;
	assign ctrl_wr = access && csr_i.we && (csr_i.adr == CSR_CTRL);

	always_comb
	begin
		case (csr_i.adr)
			CSR_CTRL: rdat = {31'b0, enable_q};
			CSR_HITS: rdat = hits_q;
			CSR_MISSES: rdat = misses_q;
			default: rdat = '0;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!rst_n)
		begin
			ack_q <= 1'b0;
			enable_q <= 1'b1;
			hits_q <= '0;
			misses_q <= '0;
		end
		else
		begin
			ack_q <= access;
			if (ctrl_wr)
			begin
				enable_q <= csr_i.dat[0];
				hits_q <= '0;
				misses_q <= '0;
			end
			else
			begin
				// counters stick at all ones
				if (evt.hit_evt && hits_q != '1)
					hits_q <= hits_q + 32'd1;
				if (evt.miss_evt && misses_q != '1)
					misses_q <= misses_q + 32'd1;
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (access)
			rdat_q <= rdat;
	end

	assign csr_o.ack = ack_q;
	assign csr_o.dat = rdat_q;
	assign cfg.enable = enable_q;

	// ack lands on a held strobe and lasts one cycle
	a_ack_single: assert property (@(posedge CLK) disable iff (!rst_n)
		csr_o.ack |-> (csr_i.cyc && csr_i.stb) ##1 !csr_o.ack);

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  cpu_types_pkg::dp_req_t req,
	input  logic                   halt,
	output cpu_types_pkg::dp_rsp_t rsp,
	output logic                   flushed,
	output cpu_types_pkg::wb_m2s_t mem_o,
	input  cpu_types_pkg::wb_s2m_t mem_i,
	input  cpu_types_pkg::wb_m2s_t csr_i,
	output cpu_types_pkg::wb_s2m_t csr_o
);
	import cpu_types_pkg::*;

	csr_cfg_t cfg;
	csr_evt_t evt;

	// array lookup and update
	dcache_addr_u addr;
	logic tag_match;
	logic valid;
	logic dirty;
	logic [TAG_W-1:0] victim_tag;
	word_t rdata;
	logic fill_we;
	logic fill_blkoff;
	word_t fill_data;
	logic store_we;
	word_t store_data;
	logic set_valid;
	logic [INDEX_W-1:0] flush_idx;
	logic use_flush_idx;
	logic clear_dirty;

	dcache_ctrl i_dcache_ctrl (.*);

	dcache_array i_dcache_array (.*);

	dcache_csr i_dcache_csr (.*);

endmodule

/* dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;
	import cpu_types_pkg::*;

	localparam int TIMEOUT = 200;

	typedef struct packed {
		logic  we;
		word_t adr;
		word_t dat;
	} bus_rec_t;

	logic CLK;
	logic rst_n;
	dp_req_t req;
	logic halt;
	dp_rsp_t rsp;
	logic flushed;
	wb_m2s_t mem_o;
	wb_s2m_t mem_i;
	wb_m2s_t csr_i;
	wb_s2m_t csr_o;

	word_t mem [word_t];
	bus_rec_t bus_log [$];
	bus_rec_t exp_q [$];
	logic pending;
	int delay;

	// shadow of the cache contents
	logic sh_valid [8];
	logic sh_dirty [8];
	logic [TAG_W-1:0] sh_tag [8];
	word_t sh_data [8][2];
	logic enable;
	int hit_cnt;
	int miss_cnt;
	int errors;
	int timeouts;

	dcache_top i_dcache_top (.*);

	always #4 CLK = ~CLK;

	function automatic word_t mem_word(input word_t a);
		if (mem.exists(a))
			return mem[a];
		return a ^ 32'h5a5a_0000;
	endfunction

	task automatic check_value(input logic [64:0] got, input logic [64:0] exp,
		input string msg);
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, msg, got, exp);
		end
	endtask

	task automatic compare_bus_log(input int base, input string what);
		int i;
		check_value(bus_log.size() - base, exp_q.size(), {what, " bus cycle count"});
		for (i = 0; i < exp_q.size() && base + i < bus_log.size(); i++)
			check_value(bus_log[base + i], exp_q[i], {what, " bus cycle"});
	endtask

	// wishbone memory with 0 to 3 wait states
	initial
	begin
		void'($urandom(32'hcd2c_9449));
		forever
		begin
			@(negedge CLK);
			if (mem_i.ack)
				mem_i.ack = 1'b0;
			else if (rst_n && mem_o.cyc && mem_o.stb)
			begin
				if (!pending)
				begin
					pending = 1'b1;
					delay = $urandom % 4;
				end
				if (delay == 0)
				begin
					pending = 1'b0;
					bus_log.push_back({mem_o.we, mem_o.adr, mem_o.we ? mem_o.dat : 32'h0});
					if (mem_o.we)
						mem[mem_o.adr] = mem_o.dat;
					else
						mem_i.dat = mem_word(mem_o.adr);
					mem_i.ack = 1'b1;
				end
				else
					delay--;
			end
		end
	end

	task automatic cache_access(input logic wr, input word_t a, input word_t d,
		output word_t got);
		int n;
		int base;
		logic done;
		logic cyc_seen;
		logic exp_hit;
		logic [INDEX_W-1:0] idx;
		word_t blk;
		idx = a[5:3];
		blk = {a[31:3], 3'b000};
		exp_hit = enable && sh_valid[idx] && sh_tag[idx] == a[31:6];
		exp_q.delete();
		if (!enable)
			exp_q.push_back({wr, a, wr ? d : 32'h0});
		else if (!exp_hit)
		begin
			// dirty victim leaves first in offset order
			if (sh_valid[idx] && sh_dirty[idx])
			begin
				exp_q.push_back({1'b1, sh_tag[idx], idx, 3'b000, sh_data[idx][0]});
				exp_q.push_back({1'b1, sh_tag[idx], idx, 3'b100, sh_data[idx][1]});
			end
			exp_q.push_back({1'b0, blk, 32'h0});
			exp_q.push_back({1'b0, blk | 32'h4, 32'h0});
		end
		base = bus_log.size();
		got = '0;
		done = 1'b0;
		cyc_seen = 1'b0;
		n = 0;
		req.ren = !wr;
		req.wen = wr;
		req.addr.raw = a;
		req.store = d;
		while (!done && n < TIMEOUT)
		begin
			@(posedge CLK);
			cyc_seen = cyc_seen | mem_o.cyc;
			if (rsp.hit)
			begin
				done = 1'b1;
				got = rsp.load;
			end
			n++;
		end
		@(negedge CLK);
		req = '0;
		if (!done)
		begin
			$display("timeout: access to %h got no response in %0d cycles", a, TIMEOUT);
			timeouts++;
			return;
		end
		compare_bus_log(base, "access");
		if (exp_hit)
		begin
			check_value(cyc_seen, 1'b0, "bus active during a hit");
			hit_cnt++;
		end
		else
			miss_cnt++;
		if (enable && !exp_hit)
		begin
			sh_valid[idx] = 1'b1;
			sh_dirty[idx] = 1'b0;
			sh_tag[idx] = a[31:6];
			sh_data[idx][0] = mem_word(blk);
			sh_data[idx][1] = mem_word(blk | 32'h4);
		end
		if (enable && wr)
		begin
			sh_data[idx][a[2]] = d;
			sh_dirty[idx] = 1'b1;
		end
	endtask

	task automatic csr_access(input logic we, input word_t a, input word_t d,
		output word_t got);
		int n;
		logic done;
		got = '0;
		done = 1'b0;
		n = 0;
		csr_i.cyc = 1'b1;
		csr_i.stb = 1'b1;
		csr_i.we = we;
		csr_i.adr = a;
		csr_i.dat = d;
		while (!done && n < TIMEOUT)
		begin
			@(posedge CLK);
			if (csr_o.ack)
			begin
				done = 1'b1;
				got = csr_o.dat;
			end
			n++;
		end
		@(negedge CLK);
		csr_i = '0;
		if (!done)
		begin
			$display("timeout: csr access to %h was never acknowledged", a);
			timeouts++;
		end
		else if (we && a == CSR_CTRL)
		begin
			enable = d[0];
			hit_cnt = 0;
			miss_cnt = 0;
		end
	endtask

	task automatic flush_cache();
		int n;
		int i;
		int base;
		logic done;
		exp_q.delete();
		for (i = 0; i < 8; i++)
		begin
			if (sh_valid[i] && sh_dirty[i])
			begin
				exp_q.push_back({1'b1, sh_tag[i], INDEX_W'(i), 3'b000, sh_data[i][0]});
				exp_q.push_back({1'b1, sh_tag[i], INDEX_W'(i), 3'b100, sh_data[i][1]});
			end
		end
		base = bus_log.size();
		done = 1'b0;
		n = 0;
		halt = 1'b1;
		while (!done && n < TIMEOUT)
		begin
			@(posedge CLK);
			done = flushed;
			n++;
		end
		@(negedge CLK);
		if (!done)
		begin
			$display("timeout: flushed did not rise within %0d cycles of halt", TIMEOUT);
			timeouts++;
			return;
		end
		compare_bus_log(base, "flush");
		for (i = 0; i < 8; i++)
		begin
			if (sh_valid[i] && sh_dirty[i])
			begin
				check_value(mem_word({sh_tag[i], INDEX_W'(i), 3'b000}), sh_data[i][0],
					"flushed word 0");
				check_value(mem_word({sh_tag[i], INDEX_W'(i), 3'b100}), sh_data[i][1],
					"flushed word 1");
				sh_dirty[i] = 1'b0;
			end
		end
	endtask

	initial
	begin
		int fd;
		int code;
		int i;
		logic [7:0] op;
		logic finished;
		word_t a;
		word_t d;
		word_t e;
		word_t got;
		CLK = 1'b0;
		rst_n = 1'b0;
		req = '0;
		halt = 1'b0;
		mem_i = '0;
		csr_i = '0;
		pending = 1'b0;
		delay = 0;
		errors = 0;
		timeouts = 0;
		hit_cnt = 0;
		miss_cnt = 0;
		enable = 1'b1;
		for (i = 0; i < 8; i++)
		begin
			sh_valid[i] = 1'b0;
			sh_dirty[i] = 1'b0;
		end
		repeat (4) @(negedge CLK);
		rst_n = 1'b1;
		fd = $fopen("dcache_input.txt", "r");
		if (fd == 0)
		begin
			$display("could not open dcache_input.txt");
			errors++;
		end
		finished = (fd == 0);
		while (!finished)
		begin
			code = $fscanf(fd, " %c", op);
			if (code != 1)
				finished = 1'b1;
			else if (op == "#")
			begin
				code = $fgetc(fd);
				while (code != 10 && code != -1)
					code = $fgetc(fd);
			end
			else
			begin
				code = $fscanf(fd, "%h %h %h", a, d, e);
				if (code != 3)
				begin
					$display("malformed line in dcache_input.txt for op %c", op);
					errors++;
				end
				case (op)
					"L":
					begin
						cache_access(1'b0, a, d, got);
						if (timeouts == 0)
							check_value(got, e, "load data");
					end
					"S": cache_access(1'b1, a, d, got);
					"C": csr_access(1'b1, a, d, got);
					"R":
					begin
						csr_access(1'b0, a, 32'h0, got);
						if (timeouts == 0)
						begin
							check_value(got, e, "csr read");
							if (a == CSR_HITS)
								check_value(got, hit_cnt, "hit counter");
							else if (a == CSR_MISSES)
								check_value(got, miss_cnt, "miss counter");
						end
					end
					"H": flush_cache();
					default:
					begin
						$display("unknown op %c in dcache_input.txt", op);
						errors++;
					end
				endcase
			end
			if (timeouts != 0)
				finished = 1'b1;
		end
		if (fd != 0)
			$fclose(fd);
		$display("errors: %0d  timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* all.f */
cpu_types_pkg.sv
dcache_array.sv
dcache_ctrl.sv
dcache_csr.sv
dcache_top.sv
dcache_tb.sv

/* dcache_input.txt */
# op address data expected, all in hex after the op letter
# L load  S store  C csr write  R csr read  H halt  (expected is used by L and R)
L 00000100 00000000 5a5a0100
L 00000104 00000000 5a5a0104
S 00000108 11112222 00000000
L 00000108 00000000 11112222
L 0000010c 00000000 5a5a010c
S 0000010c 33334444 00000000
L 00000148 00000000 5a5a0148
L 00000108 00000000 11112222
R 00000004 00000000 00000004
R 00000008 00000000 00000004
S 00000110 aaaa0001 00000000
C 00000000 00000000 00000000
R 00000000 00000000 00000000
R 00000004 00000000 00000000
R 00000008 00000000 00000000
L 00000200 00000000 5a5a0200
S 00000204 bbbb0002 00000000
L 00000204 00000000 bbbb0002
R 00000008 00000000 00000003
R 00000004 00000000 00000000
C 00000000 00000001 00000000
R 00000000 00000000 00000001
L 00000204 00000000 bbbb0002
L 00000200 00000000 5a5a0200
S 00000118 cccc0003 00000000
S 0000011c dddd0004 00000000
S 00000114 ffff0006 00000000
L 00000110 00000000 aaaa0001
R 00000004 00000000 00000004
R 00000008 00000000 00000002
H 00000000 00000000 00000000
